//--- verilog/cdc_pkg.sv
/*
 * Shared constants of the clearable two-phase CDC:
 * transferred word width, synchronizer depth and the
 * state encoding of the clear sequencer.
 */
`default_nettype none

package cdc_pkg;

  // Width of one transferred word
  localparam int unsigned DATA_WIDTH = 32;

  // Flip-flops in every cross-domain synchronizer
  localparam int unsigned SYNC_STAGES = 2;

  // One sequencer of this type runs in each clock domain
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ISOLATE = 2'd1,
    CLEAR   = 2'd2,
    RELEASE = 2'd3
  } clear_state_e;

endpackage

`default_nettype wire

//--- verilog/cdc_2phase_src.sv
/*
 * Source half of the two-phase CDC. Holds one word, toggles the
 * request and waits for the synchronized acknowledge to match.
 */
`default_nettype none

module cdc_2phase_src (
  input  wire logic                           src_clk_i,
  input  wire logic                           src_rst_ni,
  input  wire logic                           clear_i,
  input  wire logic [cdc_pkg::DATA_WIDTH-1:0] data_i,
  input  wire logic                           valid_i,
  output logic                                ready_o,
  output logic                                async_req_o,
  input  wire logic                           async_ack_i,
  output logic      [cdc_pkg::DATA_WIDTH-1:0] async_data_o
);

  import cdc_pkg::*;

  logic                   req_q;
  logic [DATA_WIDTH-1:0]  data_q;
  logic [SYNC_STAGES-1:0] ack_sync_q;
  logic                   ack_synced;
  logic                   accept;

  assign ack_synced = ack_sync_q[SYNC_STAGES-1];

  // Idle once the destination has echoed the last request toggle
  assign ready_o = (ack_synced == req_q);
  assign accept  = valid_i & ready_o;

  always_ff @(posedge src_clk_i, negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      req_q      <= 1'b0;
      ack_sync_q <= '0;
    end else if (clear_i) begin
      req_q      <= 1'b0;
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[SYNC_STAGES-2:0], async_ack_i};
      if (accept) begin
        req_q <= ~req_q;
      end
    end
  end

  // The word sits here for the whole flight, so it is written only on acceptance
  always_ff @(posedge src_clk_i) begin
    if (clear_i) begin
      data_q <= '0;
    end else if (accept) begin
      data_q <= data_i;
    end
  end

  assign async_req_o  = req_q;
  assign async_data_o = data_q;

  // The destination samples the word at an unknown time after the toggle
  data_held_in_flight: assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    (!clear_i && req_q != ack_synced) |=> $stable(async_data_o)
  );

endmodule

`default_nettype wire

//--- verilog/cdc_2phase_dst.sv
/*
 * Destination half of the two-phase CDC. Synchronizes the request,
 * presents the word with valid and ready and toggles the acknowledge
 * when the word is taken.
 */
`default_nettype none

module cdc_2phase_dst (
  input  wire logic                           dst_clk_i,
  input  wire logic                           dst_rst_ni,
  input  wire logic                           clear_i,
  output logic      [cdc_pkg::DATA_WIDTH-1:0] data_o,
  output logic                                valid_o,
  input  wire logic                           ready_i,
  input  wire logic                           async_req_i,
  output logic                                async_ack_o,
  input  wire logic [cdc_pkg::DATA_WIDTH-1:0] async_data_i
);

  import cdc_pkg::*;

  logic                   ack_q;
  logic                   valid_q;
  logic [DATA_WIDTH-1:0]  data_q;
  logic [SYNC_STAGES-1:0] req_sync_q;
  logic                   req_synced;
  logic                   pending;
  logic                   accept;

  assign req_synced = req_sync_q[SYNC_STAGES-1];

  // A request toggle not yet echoed means a word is waiting on async_data_i
  assign pending = (req_synced != ack_q);
  assign accept  = valid_q & ready_i;

  always_ff @(posedge dst_clk_i, negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      ack_q      <= 1'b0;
      valid_q    <= 1'b0;
      req_sync_q <= '0;
    end else if (clear_i) begin
      ack_q      <= 1'b0;
      valid_q    <= 1'b0;
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[SYNC_STAGES-2:0], async_req_i};
      if (accept) begin
        ack_q   <= ~ack_q;
        valid_q <= 1'b0;
      end else begin
        // Follows the compare, so a request withdrawn by a source clear drops valid
        valid_q <= pending;
      end
    end
  end

  // The source holds the word stable until the acknowledge comes back
  always_ff @(posedge dst_clk_i) begin
    if (pending && !valid_q) begin
      data_q <= async_data_i;
    end
  end

  assign data_o      = data_q;
  assign valid_o     = valid_q;
  assign async_ack_o = ack_q;

  data_stable_under_backpressure: assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (valid_o && !ready_i) |=> $stable(data_o)
  );

endmodule

`default_nettype wire

//--- verilog/cdc_clear_ctrl.sv
/*
 * Clear sequencer spanning both clock domains. Each side isolates,
 * waits for its peer, pulses clear and releases once both halves
 * are clean. Request and acknowledge levels cross both ways.
 */
`default_nettype none

module cdc_clear_ctrl (
  input  wire logic src_clk_i,
  input  wire logic src_rst_ni,
  input  wire logic dst_clk_i,
  input  wire logic dst_rst_ni,
  input  wire logic src_clear_i,
  output logic      src_clear_o,
  input  wire logic src_clear_ack_i,
  output logic      src_isolate_o,
  input  wire logic src_isolate_ack_i,
  output logic      src_pending_o,
  input  wire logic dst_clear_i,
  output logic      dst_clear_o,
  input  wire logic dst_clear_ack_i,
  output logic      dst_isolate_o,
  input  wire logic dst_isolate_ack_i,
  output logic      dst_pending_o
);

  import cdc_pkg::*;

  // req is high from the start of a sequence until that side is cleared.
  // ack is high while that side is isolated and has seen the peer's req,
  // and falls again once the peer's req is seen low.
  clear_state_e           src_state_q, dst_state_q;
  logic                   src_req_q, src_ack_q, src_iso_q, src_clr_q;
  logic                   dst_req_q, dst_ack_q, dst_iso_q, dst_clr_q;
  logic [SYNC_STAGES-1:0] src_peer_req_q, src_peer_ack_q;
  logic [SYNC_STAGES-1:0] dst_peer_req_q, dst_peer_ack_q;
  logic                   src_peer_req, src_peer_ack;
  logic                   dst_peer_req, dst_peer_ack;

  assign src_peer_req = src_peer_req_q[SYNC_STAGES-1];
  assign src_peer_ack = src_peer_ack_q[SYNC_STAGES-1];
  assign dst_peer_req = dst_peer_req_q[SYNC_STAGES-1];
  assign dst_peer_ack = dst_peer_ack_q[SYNC_STAGES-1];

  always_ff @(posedge src_clk_i, negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_state_q    <= IDLE;
      src_req_q      <= 1'b0;
      src_ack_q      <= 1'b0;
      src_iso_q      <= 1'b0;
      src_clr_q      <= 1'b0;
      src_peer_req_q <= '0;
      src_peer_ack_q <= '0;
    end else begin
      src_peer_req_q <= {src_peer_req_q[SYNC_STAGES-2:0], dst_req_q};
      src_peer_ack_q <= {src_peer_ack_q[SYNC_STAGES-2:0], dst_ack_q};
      src_clr_q      <= 1'b0;
      unique case (src_state_q)
        IDLE: begin
          // A request from either side starts the same sequence
          if (src_clear_i || src_peer_req) begin
            src_state_q <= ISOLATE;
            src_req_q   <= 1'b1;
            src_iso_q   <= 1'b1;
          end
        end
        ISOLATE: begin
          if (src_isolate_ack_i && src_peer_req) begin
            src_ack_q <= 1'b1;
          end
          if (src_ack_q && src_peer_ack) begin
            src_state_q <= CLEAR;
            src_clr_q   <= 1'b1;
          end
        end
        CLEAR: begin
          if (src_clear_ack_i) begin
            src_state_q <= RELEASE;
            src_req_q   <= 1'b0;
          end
        end
        RELEASE: begin
          if (!src_peer_req) begin
            src_ack_q <= 1'b0;
          end
          // Peer is cleared and has seen that this side is cleared too
          if (!src_ack_q && !src_peer_ack) begin
            src_state_q <= IDLE;
            src_iso_q   <= 1'b0;
          end
        end
        default: src_state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge dst_clk_i, negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_state_q    <= IDLE;
      dst_req_q      <= 1'b0;
      dst_ack_q      <= 1'b0;
      dst_iso_q      <= 1'b0;
      dst_clr_q      <= 1'b0;
      dst_peer_req_q <= '0;
      dst_peer_ack_q <= '0;
    end else begin
      dst_peer_req_q <= {dst_peer_req_q[SYNC_STAGES-2:0], src_req_q};
      dst_peer_ack_q <= {dst_peer_ack_q[SYNC_STAGES-2:0], src_ack_q};
      dst_clr_q      <= 1'b0;
      unique case (dst_state_q)
        IDLE: begin
          if (dst_clear_i || dst_peer_req) begin
            dst_state_q <= ISOLATE;
            dst_req_q   <= 1'b1;
            dst_iso_q   <= 1'b1;
          end
        end
        ISOLATE: begin
          if (dst_isolate_ack_i && dst_peer_req) begin
            dst_ack_q <= 1'b1;
          end
          if (dst_ack_q && dst_peer_ack) begin
            dst_state_q <= CLEAR;
            dst_clr_q   <= 1'b1;
          end
        end
        CLEAR: begin
          if (dst_clear_ack_i) begin
            dst_state_q <= RELEASE;
            dst_req_q   <= 1'b0;
          end
        end
        RELEASE: begin
          if (!dst_peer_req) begin
            dst_ack_q <= 1'b0;
          end
          if (!dst_ack_q && !dst_peer_ack) begin
            dst_state_q <= IDLE;
            dst_iso_q   <= 1'b0;
          end
        end
        default: dst_state_q <= IDLE;
      endcase
    end
  end

  assign src_clear_o   = src_clr_q;
  assign src_isolate_o = src_iso_q;
  assign src_pending_o = src_iso_q;
  assign dst_clear_o   = dst_clr_q;
  assign dst_isolate_o = dst_iso_q;
  assign dst_pending_o = dst_iso_q;

  // A half is only ever cleared while isolated, and pending outlasts the clear
  src_clear_isolated: assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    src_clear_o |-> src_isolate_o ##1 src_pending_o
  );

  dst_clear_isolated: assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    dst_clear_o |-> dst_isolate_o ##1 dst_pending_o
  );

endmodule

`default_nettype wire

//--- verilog/cdc_2phase_clearable.sv
/*
 * Clearable two-phase CDC top level. Joins the source and destination
 * halves with the clear sequencer, masks valid and ready while isolated
 * and registers the isolate and clear acknowledges.
 */
`default_nettype none

module cdc_2phase_clearable (
  input  wire logic                           src_clk_i,
  input  wire logic                           src_rst_ni,
  input  wire logic                           src_clear_i,
  input  wire logic [cdc_pkg::DATA_WIDTH-1:0] src_data_i,
  input  wire logic                           src_valid_i,
  output logic                                src_ready_o,
  output logic                                src_clear_pending_o,
  input  wire logic                           dst_clk_i,
  input  wire logic                           dst_rst_ni,
  input  wire logic                           dst_clear_i,
  output logic      [cdc_pkg::DATA_WIDTH-1:0] dst_data_o,
  output logic                                dst_valid_o,
  input  wire logic                           dst_ready_i,
  output logic                                dst_clear_pending_o
);

  import cdc_pkg::*;

  logic                  async_req;
  logic                  async_ack;
  logic [DATA_WIDTH-1:0] async_data;

  logic src_isolate, src_clear, src_ready;
  logic src_isolate_ack_q, src_clear_ack_q;
  logic dst_isolate, dst_clear, dst_valid;
  logic dst_isolate_ack_q, dst_clear_ack_q;

  cdc_2phase_src i_src (
    .src_clk_i    (src_clk_i),
    .src_rst_ni   (src_rst_ni),
    .clear_i      (src_clear),
    .data_i       (src_data_i),
    .valid_i      (src_valid_i & ~src_isolate),
    .ready_o      (src_ready),
    .async_req_o  (async_req),
    .async_ack_i  (async_ack),
    .async_data_o (async_data)
  );

  assign src_ready_o = src_ready & ~src_isolate;

  cdc_2phase_dst i_dst (
    .dst_clk_i    (dst_clk_i),
    .dst_rst_ni   (dst_rst_ni),
    .clear_i      (dst_clear),
    .data_o       (dst_data_o),
    .valid_o      (dst_valid),
    .ready_i      (dst_ready_i & ~dst_isolate),
    .async_req_i  (async_req),
    .async_ack_o  (async_ack),
    .async_data_i (async_data)
  );

  assign dst_valid_o = dst_valid & ~dst_isolate;

  cdc_clear_ctrl i_clear_ctrl (
    .src_clk_i         (src_clk_i),
    .src_rst_ni        (src_rst_ni),
    .dst_clk_i         (dst_clk_i),
    .dst_rst_ni        (dst_rst_ni),
    .src_clear_i       (src_clear_i),
    .src_clear_o       (src_clear),
    .src_clear_ack_i   (src_clear_ack_q),
    .src_isolate_o     (src_isolate),
    .src_isolate_ack_i (src_isolate_ack_q),
    .src_pending_o     (src_clear_pending_o),
    .dst_clear_i       (dst_clear_i),
    .dst_clear_o       (dst_clear),
    .dst_clear_ack_i   (dst_clear_ack_q),
    .dst_isolate_o     (dst_isolate),
    .dst_isolate_ack_i (dst_isolate_ack_q),
    .dst_pending_o     (dst_clear_pending_o)
  );

  // Masking valid and ready takes effect at once, so one register is enough
  always_ff @(posedge src_clk_i, negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_isolate_ack_q <= 1'b0;
      src_clear_ack_q   <= 1'b0;
    end else begin
      src_isolate_ack_q <= src_isolate;
      src_clear_ack_q   <= src_clear;
    end
  end

  always_ff @(posedge dst_clk_i, negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_isolate_ack_q <= 1'b0;
      dst_clear_ack_q   <= 1'b0;
    end else begin
      dst_isolate_ack_q <= dst_isolate;
      dst_clear_ack_q   <= dst_clear;
    end
  end

endmodule

`default_nettype wire

//--- test/tb_cdc_2phase_clearable.sv
/*
 * Testbench for the clearable two-phase CDC. Two unrelated clocks,
 * random traffic with back-pressure, clears from either side or both,
 * and a scoreboard queue checked by assertions.
 */
`default_nettype none

module tb_cdc_2phase_clearable;

  timeunit 1ns;
  timeprecision 1ps;

  import cdc_pkg::*;

  localparam logic [31:0] SEED       = 32'h9ced7c3d;
  localparam int unsigned WAIT_LIMIT = 100 * SYNC_STAGES;

  logic                  src_clk_i, src_rst_ni, src_clear_i, src_valid_i;
  logic                  dst_clk_i, dst_rst_ni, dst_clear_i, dst_ready_i;
  logic [DATA_WIDTH-1:0] src_data_i, dst_data_o;
  logic                  src_ready_o, src_clear_pending_o;
  logic                  dst_valid_o, dst_clear_pending_o;

  logic [DATA_WIDTH-1:0] sb_q[$];
  logic [DATA_WIDTH-1:0] expected;
  logic [31:0]           src_rng, dst_rng, main_rng;
  int unsigned           words_target, words_sent, stall_left, delivered;
  logic                  pend_seen, dst_pend_q;

  // Rising edges at 35 + 70k and 50 + 100m never coincide
  always #35 src_clk_i = ~src_clk_i;
  always #50 dst_clk_i = ~dst_clk_i;

  cdc_2phase_clearable DUT (
    .src_clk_i           (src_clk_i),
    .src_rst_ni          (src_rst_ni),
    .src_clear_i         (src_clear_i),
    .src_data_i          (src_data_i),
    .src_valid_i         (src_valid_i),
    .src_ready_o         (src_ready_o),
    .src_clear_pending_o (src_clear_pending_o),
    .dst_clk_i           (dst_clk_i),
    .dst_rst_ni          (dst_rst_ni),
    .dst_clear_i         (dst_clear_i),
    .dst_data_o          (dst_data_o),
    .dst_valid_o         (dst_valid_o),
    .dst_ready_i         (dst_ready_i),
    .dst_clear_pending_o (dst_clear_pending_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first failed check");
  endtask

  // A new word is offered only once the previous one has been taken
  always @(posedge src_clk_i) begin
    if (!src_valid_i || src_ready_o) begin
      src_rng = xorshift32(src_rng);
      if (words_sent != words_target && src_rng[1:0] != 2'd0) begin
        src_data_i  <= src_rng;
        src_valid_i <= 1'b1;
        words_sent  <= words_sent + 1;
      end else begin
        src_valid_i <= 1'b0;
      end
    end
  end

  // Sink with random stretches of back-pressure
  always @(posedge dst_clk_i) begin
    if (stall_left != 0) begin
      stall_left  = stall_left - 1;
      dst_ready_i <= 1'b0;
    end else begin
      dst_rng = xorshift32(dst_rng);
      if (dst_rng[2:0] == 3'd0) begin
        stall_left  = {28'd0, dst_rng[7:4]};
        dst_ready_i <= 1'b0;
      end else begin
        dst_ready_i <= 1'b1;
      end
    end
  end

  // A word taken while only the destination is clearing dies in the source clear
  always @(posedge src_clk_i) begin
    if (src_valid_i && src_ready_o && (!dst_clear_pending_o || pend_seen)) begin
      sb_q.push_back(src_data_i);
    end
    if (src_clear_pending_o) begin
      pend_seen = 1'b1;
    end else if (!dst_clear_pending_o) begin
      pend_seen = 1'b0;
    end
  end

  always @(posedge dst_clk_i) begin
    if (dst_valid_o && dst_ready_i) begin
      assert (sb_q.size() != 0)
        else stop_on_error("destination delivered a word that was never sent");
      expected = sb_q.pop_front();
      assert (dst_data_o == expected)
        else stop_on_error($sformatf("error dst_data_o: got %h expected %h",
                                     dst_data_o, expected));
      delivered++;
    end
    // Whatever is still undelivered when the destination isolates is discarded
    if (dst_clear_pending_o && !dst_pend_q) begin
      sb_q.delete();
    end
    dst_pend_q = dst_clear_pending_o;
  end

  src_ready_masked: assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    src_clear_pending_o |-> !src_ready_o
  ) else stop_on_error("src_ready_o was high while the source side was clearing");

  dst_valid_masked: assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    dst_clear_pending_o |-> !dst_valid_o
  ) else stop_on_error("dst_valid_o was high while the destination side was clearing");

  dst_word_held: assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (dst_valid_o && !dst_ready_i) |=>
      ((dst_valid_o && $stable(dst_data_o)) || dst_clear_pending_o)
  ) else stop_on_error("dst_valid_o or dst_data_o moved under back-pressure");

  src_blocked_in_flight: assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    dst_valid_o |-> !src_ready_o
  ) else stop_on_error("src_ready_o was high while a word waited at the destination");

  task automatic check_reset_values();
    assert (dst_valid_o == 1'b0)
      else stop_on_error($sformatf("error dst_valid_o: got %h expected 0", dst_valid_o));
    assert (src_clear_pending_o == 1'b0)
      else stop_on_error($sformatf("error src_clear_pending_o: got %h expected 0",
                                   src_clear_pending_o));
    assert (dst_clear_pending_o == 1'b0)
      else stop_on_error($sformatf("error dst_clear_pending_o: got %h expected 0",
                                   dst_clear_pending_o));
    assert (src_ready_o == 1'b1)
      else stop_on_error($sformatf("error src_ready_o: got %h expected 1", src_ready_o));
  endtask

  task automatic wait_source_idle();
    int unsigned idle;
    int unsigned last;
    idle = 0;
    last = words_sent;
    do begin
      @(posedge src_clk_i);
      if (words_sent != last) begin
        last = words_sent;
        idle = 0;
      end else if (idle == WAIT_LIMIT) begin
        stop_on_error("timeout: the source stopped accepting words");
      end else begin
        idle++;
      end
    end while (words_sent != words_target || src_valid_i);
  endtask

  task automatic wait_drain();
    int unsigned cycles;
    cycles = 0;
    while (sb_q.size() != 0 || dst_valid_o) begin
      if (cycles == WAIT_LIMIT) begin
        stop_on_error("timeout: accepted words never reached the destination");
      end
      cycles++;
      @(posedge dst_clk_i);
    end
  endtask

  task automatic wait_pending(input bit on_src, input logic level);
    int unsigned cycles;
    cycles = 0;
    while ((on_src ? src_clear_pending_o : dst_clear_pending_o) != level) begin
      if (cycles == WAIT_LIMIT) begin
        stop_on_error($sformatf("timeout: %s clear pending never went to %0d",
                                on_src ? "source" : "destination", level));
      end
      cycles++;
      if (on_src) begin
        @(posedge src_clk_i);
      end else begin
        @(posedge dst_clk_i);
      end
    end
  endtask

  // Kind 0 clears from the source, 1 from the destination, 2 from both
  task automatic issue_clear(input int unsigned kind);
    if (kind != 1) begin
      @(posedge src_clk_i);
      src_clear_i <= 1'b1;
      @(posedge src_clk_i);
      src_clear_i <= 1'b0;
    end
    if (kind != 0) begin
      @(posedge dst_clk_i);
      dst_clear_i <= 1'b1;
      @(posedge dst_clk_i);
      dst_clear_i <= 1'b0;
    end
    wait_pending(1'b1, 1'b1);
    wait_pending(1'b0, 1'b1);
    wait_pending(1'b1, 1'b0);
    wait_pending(1'b0, 1'b0);
  endtask

  initial begin
    src_clk_i    = 1'b0;
    dst_clk_i    = 1'b0;
    src_rst_ni   = 1'b0;
    dst_rst_ni   = 1'b0;
    src_clear_i  = 1'b0;
    dst_clear_i  = 1'b0;
    src_data_i   = '0;
    src_valid_i  = 1'b0;
    dst_ready_i  = 1'b0;
    src_rng      = SEED;
    dst_rng      = xorshift32(SEED);
    main_rng     = xorshift32(dst_rng);
    words_target = 0;
    words_sent   = 0;
    stall_left   = 0;
    delivered    = 0;
    pend_seen    = 1'b0;
    dst_pend_q   = 1'b0;

    repeat (3) @(posedge dst_clk_i);
    dst_rst_ni <= 1'b1;
    @(posedge src_clk_i);
    src_rst_ni <= 1'b1;
    @(posedge dst_clk_i);
    check_reset_values();

    // Plain traffic first, then clears landing in the middle of traffic
    words_target <= words_target + 60;
    wait_source_idle();
    wait_drain();
    for (int round = 0; round < 9; round++) begin
      main_rng = xorshift32(main_rng);
      words_target <= words_target + 16;
      repeat (4 + main_rng[3:0]) @(posedge src_clk_i);
      issue_clear((round < 3) ? round : main_rng[5:4] % 3);
    end
    wait_source_idle();
    wait_drain();

    $display("%0d words delivered", delivered);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
verilog/cdc_pkg.sv
verilog/cdc_2phase_src.sv
verilog/cdc_2phase_dst.sv
verilog/cdc_clear_ctrl.sv
verilog/cdc_2phase_clearable.sv
test/tb_cdc_2phase_clearable.sv

//--- Makefile
TOP = tb_cdc_2phase_clearable

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
	  --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
